// ==== src/sched_defs.svh ====
// sizes shared by the scheduler RTL and its testbench
// PHY_REG_NUM must be larger than ARCH_REG_NUM
// the free list holds PHY_REG_NUM - ARCH_REG_NUM registers
// station depths must be powers of two

`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// register files
`define ARCH_REG_NUM 32
`define PHY_REG_NUM  64

// writeback ports feeding the wakeup network
`define WB_WIDTH 2

// reservation station depths
`define ALU_RS_SIZE 8
`define MEM_RS_SIZE 4

// instruction tag carried through untouched
`define TAG_W 8

`endif

// ==== src/sched_pkg.sv ====
// types for the single-lane rename and issue front
// operation codes arrive 4 bits wide and get narrowed per station class

`include "sched_defs.svh"

package sched_pkg;

  typedef logic [$clog2(`ARCH_REG_NUM)-1:0] areg_t;
  typedef logic [$clog2(`PHY_REG_NUM)-1:0]  preg_t;
  typedef logic [`TAG_W-1:0]                tag_t;

  typedef enum logic {
    CLS_ALU = 1'b0,
    CLS_MEM = 1'b1
  } instr_class_e;

  typedef logic [3:0] alu_oc_t;

  typedef struct packed {
    logic       store;
    logic [1:0] size;
  } mem_oc_t;

  // ==================================================
  // decode request and renamed record
  // ==================================================
  typedef struct packed {
    logic         valid;
    instr_class_e cls;
    areg_t        dest;
    areg_t        src0;
    areg_t        src1;
    logic [3:0]   oc;
    tag_t         tag;
  } sched_req_t;

  // common part of every station entry
  typedef struct packed {
    logic  dest_valid;
    preg_t pdest;
    preg_t old_pdest;
    preg_t psrc0;
    preg_t psrc1;
    logic  src0_ready;
    logic  src1_ready;
    tag_t  tag;
  } rs_base_t;

  typedef struct packed {
    logic         valid;
    instr_class_e cls;
    logic [3:0]   oc;
    rs_base_t     base;
  } ren_t;

  typedef struct packed {
    rs_base_t base;
    alu_oc_t  oc;
  } alu_entry_t;

  typedef struct packed {
    rs_base_t base;
    mem_oc_t  oc;
  } mem_entry_t;

  // ==================================================
  // issue side
  // ==================================================
  typedef struct packed {
    logic  valid;
    logic  dest_valid;
    preg_t pdest;
    preg_t old_pdest;
    preg_t psrc0;
    preg_t psrc1;
    tag_t  tag;
  } issue_base_t;

  typedef struct packed {
    issue_base_t base;
    alu_oc_t     oc;
  } alu_issue_t;

  typedef struct packed {
    issue_base_t base;
    mem_oc_t     oc;
  } mem_issue_t;

  // true when any writeback port this cycle produces p
  function automatic logic wb_hit(
    input preg_t                 p,
    input logic  [`WB_WIDTH-1:0] wb_valid,
    input preg_t [`WB_WIDTH-1:0] wb_pdest
  );
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < `WB_WIDTH; j++) begin
      hit = hit || (wb_valid[j] && (wb_pdest[j] == p));
    end
    return hit;
  endfunction

endpackage

// ==== src/free_list.sv ====
// circular FIFO of free physical registers
// holds registers ARCH_REG_NUM..PHY_REG_NUM-1 after reset
// head entry is visible combinationally before it is popped

`timescale 1ns/1ps
`include "sched_defs.svh"

module free_list (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alloc_i,
  input  logic             free_valid_i,
  input  sched_pkg::preg_t free_preg_i,
  output sched_pkg::preg_t alloc_preg_o,
  output logic             empty_o
);

  localparam int FL_SIZE = `PHY_REG_NUM - `ARCH_REG_NUM;
  localparam int PTR_W   = $clog2(FL_SIZE);

  sched_pkg::preg_t fl_mem [FL_SIZE];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W:0]   cnt_q;

  assign alloc_preg_o = fl_mem[head_q];
  assign empty_o      = (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= (PTR_W+1)'(FL_SIZE);
      // every register above the architectural range starts free
      for (int i = 0; i < FL_SIZE; i++) begin
        fl_mem[i] <= sched_pkg::preg_t'(`ARCH_REG_NUM + i);
      end
    end else begin
      if (alloc_i) begin
        head_q <= (head_q == PTR_W'(FL_SIZE - 1)) ? '0 : head_q + 1'b1;
      end
      if (free_valid_i) begin
        fl_mem[tail_q] <= free_preg_i;
        tail_q         <= (tail_q == PTR_W'(FL_SIZE - 1)) ? '0 : tail_q + 1'b1;
      end
      cnt_q <= cnt_q + (PTR_W+1)'(free_valid_i) - (PTR_W+1)'(alloc_i);
    end
  end

  // rename must hold back requests once the list runs dry
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_i |-> !empty_o);

  // commit never returns more registers than were handed out
  a_no_free_full: assert property (@(posedge clk) disable iff (!rst_n)
    free_valid_i |-> (cnt_q != (PTR_W+1)'(FL_SIZE)));

endmodule

// ==== src/rename_stage.sv ====
// alias table, ready table and free list allocation for one lane
// source lookups see the table before this instruction's own write
// the stage register holds and keeps waking up while stalled

`timescale 1ns/1ps
`include "sched_defs.svh"

module rename_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  sched_pkg::sched_req_t            req_i,
  input  logic                             stall_i,
  input  logic             [`WB_WIDTH-1:0] wb_valid_i,
  input  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_pdest_i,
  input  logic                             free_valid_i,
  input  sched_pkg::preg_t                 free_preg_i,
  output logic                             req_ready_o,
  output sched_pkg::ren_t                  ren_o
);

  sched_pkg::preg_t        rat_q [`ARCH_REG_NUM];
  logic [`PHY_REG_NUM-1:0] prdy_q;
  sched_pkg::ren_t         ren_q;

  logic                fl_empty;
  sched_pkg::preg_t    fl_preg;
  logic                need_preg;
  logic                accept;
  logic                alloc;
  sched_pkg::rs_base_t new_base;
  sched_pkg::rs_base_t held_base;

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .alloc_preg_o (fl_preg),
    .empty_o      (fl_empty)
  );

  // ==================================================
  // accept and allocation
  // ==================================================
  assign need_preg   = req_i.valid && (req_i.dest != '0);
  assign req_ready_o = !stall_i && !(fl_empty && need_preg);
  assign accept      = req_i.valid && req_ready_o;
  assign alloc       = accept && need_preg;

  always_comb begin
    new_base            = '0;
    new_base.dest_valid = (req_i.dest != '0);
    new_base.pdest      = new_base.dest_valid ? fl_preg : '0;
    new_base.old_pdest  = rat_q[req_i.dest];
    new_base.psrc0      = rat_q[req_i.src0];
    new_base.psrc1      = rat_q[req_i.src1];
    new_base.tag        = req_i.tag;
    // r0 is always ready
    new_base.src0_ready = (req_i.src0 == '0) || prdy_q[new_base.psrc0] ||
                          sched_pkg::wb_hit(new_base.psrc0, wb_valid_i, wb_pdest_i);
    new_base.src1_ready = (req_i.src1 == '0) || prdy_q[new_base.psrc1] ||
                          sched_pkg::wb_hit(new_base.psrc1, wb_valid_i, wb_pdest_i);

    // wakeup for a held instruction
    held_base            = ren_q.base;
    held_base.src0_ready = held_base.src0_ready ||
                           sched_pkg::wb_hit(held_base.psrc0, wb_valid_i, wb_pdest_i);
    held_base.src1_ready = held_base.src1_ready ||
                           sched_pkg::wb_hit(held_base.psrc1, wb_valid_i, wb_pdest_i);
  end

  // ==================================================
  // alias and ready tables
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        rat_q[i] <= sched_pkg::preg_t'(i);
      end
      prdy_q <= '1;
    end else begin
      for (int j = 0; j < `WB_WIDTH; j++) begin
        if (wb_valid_i[j]) begin
          prdy_q[wb_pdest_i[j]] <= 1'b1;
        end
      end
      // new mapping is pending until its writeback
      if (alloc) begin
        rat_q[req_i.dest] <= fl_preg;
        prdy_q[fl_preg]   <= 1'b0;
      end
    end
  end

  // stage register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ren_q <= '0;
    end else if (stall_i) begin
      ren_q.base <= held_base;
    end else begin
      ren_q.valid <= accept;
      ren_q.cls   <= req_i.cls;
      ren_q.oc    <= req_i.oc;
      ren_q.base  <= new_base;
    end
  end

  assign ren_o = ren_q;

  // dispatch only stalls on an instruction actually sitting here
  a_stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |-> ren_q.valid);

endmodule

// ==== src/dispatch_stage.sv ====
// routes the renamed instruction to its station by class
// same-cycle writebacks are folded into the source ready bits
// stall is raised when the target station cannot take the entry

`timescale 1ns/1ps
`include "sched_defs.svh"

module dispatch_stage (
  input  sched_pkg::ren_t                  ren_i,
  input  logic                             alu_wr_ready_i,
  input  logic                             mem_wr_ready_i,
  input  logic             [`WB_WIDTH-1:0] wb_valid_i,
  input  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_pdest_i,
  output logic                             alu_wr_valid_o,
  output sched_pkg::alu_entry_t            alu_entry_o,
  output logic                             mem_wr_valid_o,
  output sched_pkg::mem_entry_t            mem_entry_o,
  output logic                             stall_o
);

  sched_pkg::rs_base_t base;

  always_comb begin
    base            = ren_i.base;
    base.src0_ready = base.src0_ready ||
                      sched_pkg::wb_hit(base.psrc0, wb_valid_i, wb_pdest_i);
    base.src1_ready = base.src1_ready ||
                      sched_pkg::wb_hit(base.psrc1, wb_valid_i, wb_pdest_i);

    alu_wr_valid_o = ren_i.valid && (ren_i.cls == sched_pkg::CLS_ALU);
    mem_wr_valid_o = ren_i.valid && (ren_i.cls == sched_pkg::CLS_MEM);

    alu_entry_o.base = base;
    alu_entry_o.oc   = sched_pkg::alu_oc_t'(ren_i.oc);
    // memory ops only use the low 3 bits
    mem_entry_o.base = base;
    mem_entry_o.oc   = sched_pkg::mem_oc_t'(ren_i.oc[2:0]);

    stall_o = (alu_wr_valid_o && !alu_wr_ready_i) ||
              (mem_wr_valid_o && !mem_wr_ready_i);
  end

endmodule

// ==== src/reservation_station.sv ====
// reservation station kept as a compacting queue with entry 0 the oldest
// IN_ORDER=1 issues only the head and IN_ORDER=0 the oldest ready entry
// an empty or idle station passes a ready write straight to issue
// RS_SIZE must be a power of two

`timescale 1ns/1ps
`include "sched_defs.svh"

module reservation_station #(
  parameter int  RS_SIZE  = 8,
  parameter bit  IN_ORDER = 1'b0,
  parameter type OC_T     = logic [3:0]
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_valid_i,
  input  sched_pkg::rs_base_t              wr_base_i,
  input  OC_T                              wr_oc_i,
  input  logic             [`WB_WIDTH-1:0] wb_valid_i,
  input  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_pdest_i,
  input  logic                             issue_ready_i,
  output logic                             wr_ready_o,
  output logic [$bits(sched_pkg::issue_base_t)+$bits(OC_T)-1:0] issue_o
);

  localparam int IDX_W = $clog2(RS_SIZE);

  typedef struct packed {
    sched_pkg::rs_base_t base;
    OC_T                 oc;
  } entry_t;

  typedef struct packed {
    sched_pkg::issue_base_t base;
    OC_T                    oc;
  } issue_t;

  logic [RS_SIZE-1:0] vld_q;
  logic [RS_SIZE-1:0] vld_nxt;
  entry_t             ent_q   [RS_SIZE];
  entry_t             ent_nxt [RS_SIZE];
  issue_t             issue_q;
  issue_t             issue_nxt;

  entry_t     wr_ent;
  entry_t     sel_ent;
  logic [IDX_W-1:0] sel_idx;
  logic [IDX_W:0]   cnt;
  logic [IDX_W:0]   wr_pos;
  logic       sel_found;
  logic       bypass;
  logic       can_load;
  logic       take;
  logic       wr_fire;
  logic       wr_store;

  assign wr_ready_o = !vld_q[RS_SIZE-1];
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign wr_ent     = '{base: wr_base_i, oc: wr_oc_i};
  assign can_load   = !issue_q.base.valid || issue_ready_i;

  // ==================================================
  // selection
  // ==================================================
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    cnt       = '0;
    for (int i = 0; i < RS_SIZE; i++) begin
      cnt = cnt + (IDX_W+1)'(vld_q[i]);
    end
    if (IN_ORDER) begin
      sel_found = vld_q[0] && ent_q[0].base.src0_ready && ent_q[0].base.src1_ready;
    end else begin
      // scan down so the lowest ready index wins
      for (int i = RS_SIZE - 1; i >= 0; i--) begin
        if (vld_q[i] && ent_q[i].base.src0_ready && ent_q[i].base.src1_ready) begin
          sel_found = 1'b1;
          sel_idx   = IDX_W'(i);
        end
      end
    end

    // incoming entry is the youngest
    bypass = wr_fire && !sel_found && wr_base_i.src0_ready && wr_base_i.src1_ready &&
             (!IN_ORDER || (vld_q == '0));
    take     = can_load && (sel_found || bypass);
    sel_ent  = sel_found ? ent_q[sel_idx] : wr_ent;
    wr_store = wr_fire && !(take && !sel_found);
    wr_pos   = cnt - (IDX_W+1)'(take && sel_found);
  end

  // ==================================================
  // queue update
  // ==================================================
  always_comb begin
    vld_nxt = vld_q;
    for (int i = 0; i < RS_SIZE; i++) begin
      ent_nxt[i] = ent_q[i];
      ent_nxt[i].base.src0_ready = ent_q[i].base.src0_ready ||
          sched_pkg::wb_hit(ent_q[i].base.psrc0, wb_valid_i, wb_pdest_i);
      ent_nxt[i].base.src1_ready = ent_q[i].base.src1_ready ||
          sched_pkg::wb_hit(ent_q[i].base.psrc1, wb_valid_i, wb_pdest_i);
    end
    // close the gap left by the issued entry
    if (take && sel_found) begin
      for (int i = 0; i < RS_SIZE - 1; i++) begin
        if (i >= sel_idx) begin
          ent_nxt[i] = ent_nxt[i+1];
          vld_nxt[i] = vld_nxt[i+1];
        end
      end
      vld_nxt[RS_SIZE-1] = 1'b0;
    end
    if (wr_store) begin
      ent_nxt[wr_pos[IDX_W-1:0]] = wr_ent;
      vld_nxt[wr_pos[IDX_W-1:0]] = 1'b1;
    end

    issue_nxt.base.valid      = take;
    issue_nxt.base.dest_valid = sel_ent.base.dest_valid;
    issue_nxt.base.pdest      = sel_ent.base.pdest;
    issue_nxt.base.old_pdest  = sel_ent.base.old_pdest;
    issue_nxt.base.psrc0      = sel_ent.base.psrc0;
    issue_nxt.base.psrc1      = sel_ent.base.psrc1;
    issue_nxt.base.tag        = sel_ent.base.tag;
    issue_nxt.oc              = sel_ent.oc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      ent_q[i] <= ent_nxt[i];
    end
  end

  // issue register holds while the consumer is busy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_q <= '0;
    end else if (can_load) begin
      issue_q <= issue_nxt;
    end
  end

  assign issue_o = issue_q;

  // only woken entries reach the issue register
  a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> sel_ent.base.src0_ready && sel_ent.base.src1_ready);

endmodule

// ==== src/scheduler_top.sv ====
// single-lane rename and issue front
// one ALU station (out of order) and one memory station (in program order)
// writeback and free arrive as one-cycle pulses

`timescale 1ns/1ps
`include "sched_defs.svh"

module scheduler_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  sched_pkg::sched_req_t            req_i,
  output logic                             req_ready_o,
  input  logic             [`WB_WIDTH-1:0] wb_valid_i,
  input  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_pdest_i,
  input  logic                             free_valid_i,
  input  sched_pkg::preg_t                 free_preg_i,
  output sched_pkg::alu_issue_t            alu_issue_o,
  input  logic                             alu_ready_i,
  output sched_pkg::mem_issue_t            mem_issue_o,
  input  logic                             mem_ready_i
);

  sched_pkg::ren_t       ren;
  logic                  stall;
  logic                  alu_wr_valid;
  logic                  alu_wr_ready;
  logic                  mem_wr_valid;
  logic                  mem_wr_ready;
  sched_pkg::alu_entry_t alu_entry;
  sched_pkg::mem_entry_t mem_entry;

  rename_stage u_rename (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .stall_i      (stall),
    .wb_valid_i   (wb_valid_i),
    .wb_pdest_i   (wb_pdest_i),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .req_ready_o  (req_ready_o),
    .ren_o        (ren)
  );

  dispatch_stage u_dispatch (
    .ren_i          (ren),
    .alu_wr_ready_i (alu_wr_ready),
    .mem_wr_ready_i (mem_wr_ready),
    .wb_valid_i     (wb_valid_i),
    .wb_pdest_i     (wb_pdest_i),
    .alu_wr_valid_o (alu_wr_valid),
    .alu_entry_o    (alu_entry),
    .mem_wr_valid_o (mem_wr_valid),
    .mem_entry_o    (mem_entry),
    .stall_o        (stall)
  );

  reservation_station #(
    .RS_SIZE  (`ALU_RS_SIZE),
    .IN_ORDER (1'b0),
    .OC_T     (sched_pkg::alu_oc_t)
  ) u_alu_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (alu_wr_valid),
    .wr_base_i     (alu_entry.base),
    .wr_oc_i       (alu_entry.oc),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_ready_i (alu_ready_i),
    .wr_ready_o    (alu_wr_ready),
    .issue_o       (alu_issue_o)
  );

  reservation_station #(
    .RS_SIZE  (`MEM_RS_SIZE),
    .IN_ORDER (1'b1),
    .OC_T     (sched_pkg::mem_oc_t)
  ) u_mem_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (mem_wr_valid),
    .wr_base_i     (mem_entry.base),
    .wr_oc_i       (mem_entry.oc),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_ready_i (mem_ready_i),
    .wr_ready_o    (mem_wr_ready),
    .issue_o       (mem_issue_o)
  );

endmodule

// ==== testbench/tb_scheduler.sv ====
// testbench for the single-lane rename and issue front
// reads testbench/scheduler_input.txt relative to the project root
// tags in the data file must be unique
// the testbench acts as ROB and execution units
// ALU results write back on port 0 and memory results on port 1

`timescale 1ns/1ps
`include "sched_defs.svh"

module tb_scheduler;

  localparam int MAX_INSTR = 64;
  localparam int FIELDS    = 7;
  localparam int N_TESTS   = 5;
  localparam int TAGS      = 1 << `TAG_W;

  logic                             clk;
  logic                             rst_n;
  sched_pkg::sched_req_t            req;
  logic                             req_ready;
  logic             [`WB_WIDTH-1:0] wb_valid;
  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_pdest;
  logic                             free_valid;
  sched_pkg::preg_t                 free_preg;
  sched_pkg::alu_issue_t            alu_issue;
  logic                             alu_ready;
  sched_pkg::mem_issue_t            mem_issue;
  logic                             mem_ready;

  // stimulus image with FIELDS bytes per instruction
  logic [7:0] stim [0:FIELDS*MAX_INSTR-1];
  int         n_instr;
  int         next_idx;
  int         commit_ptr;
  int         seed;
  int         stall_cycles;
  int         last_mem_seq;
  int         n_checks;
  int         test_err [N_TESTS];
  int         total_err;
  int         n_passed;
  logic       finished;

  // ==================================================
  // reference model
  // ==================================================
  sched_pkg::preg_t m_rat   [`ARCH_REG_NUM];
  sched_pkg::preg_t m_free  [$];
  logic             m_ready [`PHY_REG_NUM];

  // expected results indexed by tag
  logic             accepted  [TAGS];
  logic             done      [TAGS];
  logic             exp_dv    [TAGS];
  logic             exp_port  [TAGS];
  logic [3:0]       exp_oc    [TAGS];
  sched_pkg::preg_t exp_pdest [TAGS];
  sched_pkg::preg_t exp_old   [TAGS];
  sched_pkg::preg_t exp_psrc0 [TAGS];
  sched_pkg::preg_t exp_psrc1 [TAGS];
  int               seq_of_tag [TAGS];
  int               issue_cnt  [TAGS];
  sched_pkg::tag_t  prog_tag   [MAX_INSTR];
  sched_pkg::tag_t  commit_tag;

  // writeback delay line with three stages per port
  logic             wbp_v    [`WB_WIDTH][3];
  sched_pkg::preg_t wbp_p    [`WB_WIDTH][3];
  sched_pkg::tag_t  wbp_t    [`WB_WIDTH][3];
  logic             wb_new_v [`WB_WIDTH];
  sched_pkg::preg_t wb_new_p [`WB_WIDTH];
  sched_pkg::tag_t  wb_new_t [`WB_WIDTH];
  logic             [`WB_WIDTH-1:0] wb_v_drv;
  sched_pkg::preg_t [`WB_WIDTH-1:0] wb_p_drv;

  sched_pkg::alu_issue_t prev_alu;
  sched_pkg::mem_issue_t prev_mem;
  logic                  alu_held;
  logic                  mem_held;

  scheduler_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .wb_valid_i   (wb_valid),
    .wb_pdest_i   (wb_pdest),
    .free_valid_i (free_valid),
    .free_preg_i  (free_preg),
    .alu_issue_o  (alu_issue),
    .alu_ready_i  (alu_ready),
    .mem_issue_o  (mem_issue),
    .mem_ready_i  (mem_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input int test, input string msg,
                       input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      test_err[test]++;
      $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  function automatic string test_name(input int test);
    case (test)
      0:       return "reset";
      1:       return "rename";
      2:       return "wakeup";
      3:       return "ordering";
      default: return "backpressure";
    endcase
  endfunction

  task automatic report_test(input int test);
    $display("test %-13s %s (%0d errors)", test_name(test),
             (test_err[test] == 0) ? "ok" : "FAILED", test_err[test]);
  endtask

  function automatic sched_pkg::sched_req_t make_req(input int idx);
    sched_pkg::sched_req_t r;
    int                    b;
    b       = idx * FIELDS;
    r.valid = 1'b1;
    r.cls   = sched_pkg::instr_class_e'(stim[b][0]);
    r.dest  = sched_pkg::areg_t'(stim[b+1]);
    r.src0  = sched_pkg::areg_t'(stim[b+2]);
    r.src1  = sched_pkg::areg_t'(stim[b+3]);
    r.oc    = stim[b+4][3:0];
    r.tag   = stim[b+5];
    return r;
  endfunction

  // sources read the table before the instruction's own mapping
  task automatic model_accept(input int idx);
    int               b;
    sched_pkg::tag_t  t;
    sched_pkg::areg_t d;
    b = idx * FIELDS;
    t = stim[b+5];
    d = sched_pkg::areg_t'(stim[b+1]);
    accepted[t]   = 1'b1;
    seq_of_tag[t] = idx;
    prog_tag[idx] = t;
    exp_port[t]   = stim[b+6][0];
    exp_oc[t]     = stim[b][0] ? {1'b0, stim[b+4][2:0]} : stim[b+4][3:0];
    exp_psrc0[t]  = m_rat[sched_pkg::areg_t'(stim[b+2])];
    exp_psrc1[t]  = m_rat[sched_pkg::areg_t'(stim[b+3])];
    exp_old[t]    = m_rat[d];
    exp_dv[t]     = (d != '0);
    exp_pdest[t]  = '0;
    if (d != '0) begin
      if (m_free.size() == 0) begin
        test_err[1]++;
        $display("error at %0t ns: tag %0h accepted while the model free list is empty",
                 $time, t);
      end else begin
        exp_pdest[t]          = m_free.pop_front();
        m_rat[d]              = exp_pdest[t];
        m_ready[exp_pdest[t]] = 1'b0;
      end
    end
  endtask

  task automatic take_issue(input int port, input sched_pkg::issue_base_t ib,
                            input logic [3:0] oc);
    sched_pkg::tag_t t;
    t = ib.tag;
    check(1, $sformatf("tag %0h accepted before issue", t), accepted[t], 1);
    check(1, $sformatf("tag %0h issue port", t), port, exp_port[t]);
    check(1, $sformatf("tag %0h dest_valid", t), ib.dest_valid, exp_dv[t]);
    if (exp_dv[t]) begin
      check(1, $sformatf("tag %0h pdest", t), ib.pdest, exp_pdest[t]);
      check(1, $sformatf("tag %0h old_pdest", t), ib.old_pdest, exp_old[t]);
    end
    check(1, $sformatf("tag %0h psrc0", t), ib.psrc0, exp_psrc0[t]);
    check(1, $sformatf("tag %0h psrc1", t), ib.psrc1, exp_psrc1[t]);
    check(1, $sformatf("tag %0h operation code", t), oc, exp_oc[t]);
    // p0 never leaves the ready state
    check(2, $sformatf("tag %0h src0 written back", t), m_ready[exp_psrc0[t]], 1);
    check(2, $sformatf("tag %0h src1 written back", t), m_ready[exp_psrc1[t]], 1);
    if (port == 1) begin
      check(3, $sformatf("tag %0h memory program order", t),
            seq_of_tag[t] > last_mem_seq, 1);
      last_mem_seq = seq_of_tag[t];
    end
    issue_cnt[t]++;
    if (ib.dest_valid) begin
      wb_new_v[port] = 1'b1;
      wb_new_p[port] = ib.pdest;
      wb_new_t[port] = t;
    end else begin
      done[t] = 1'b1;
    end
  endtask

  task automatic check_hold();
    if (alu_held) begin
      check(4, "alu issue held under back-pressure", alu_issue, prev_alu);
    end
    if (mem_held) begin
      check(4, "memory issue held under back-pressure", mem_issue, prev_mem);
    end
    prev_alu = alu_issue;
    prev_mem = mem_issue;
    alu_held = alu_issue.base.valid && !alu_ready;
    mem_held = mem_issue.base.valid && !mem_ready;
  endtask

  // oldest stage feeds the writeback ports
  task automatic shift_wb();
    for (int j = 0; j < `WB_WIDTH; j++) begin
      wb_v_drv[j] = wbp_v[j][2];
      wb_p_drv[j] = wbp_p[j][2];
      if (wbp_v[j][2]) begin
        m_ready[wbp_p[j][2]] = 1'b1;
        done[wbp_t[j][2]]    = 1'b1;
      end
      for (int k = 2; k > 0; k--) begin
        wbp_v[j][k] = wbp_v[j][k-1];
        wbp_p[j][k] = wbp_p[j][k-1];
        wbp_t[j][k] = wbp_t[j][k-1];
      end
      wbp_v[j][0] = wb_new_v[j];
      wbp_p[j][0] = wb_new_p[j];
      wbp_t[j][0] = wb_new_t[j];
      wb_new_v[j] = 1'b0;
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    rst_n      <= 1'b0;
    req        <= '0;
    wb_valid   <= '0;
    wb_pdest   <= '0;
    free_valid <= 1'b0;
    free_preg  <= '0;
    alu_ready  <= 1'b0;
    mem_ready  <= 1'b0;
    seed = 38;
    last_mem_seq = -1;
    finished = 1'b0;
    alu_held = 1'b0;
    mem_held = 1'b0;
    for (int i = 0; i < FIELDS * MAX_INSTR; i++) begin
      stim[i] = 8'hFF;
    end
    $readmemh("testbench/scheduler_input.txt", stim);
    for (int i = 0; i < MAX_INSTR; i++) begin
      if (n_instr == i && stim[i*FIELDS] !== 8'hFF) begin
        n_instr = i + 1;
      end
    end
    for (int i = 0; i < `ARCH_REG_NUM; i++) begin
      m_rat[i] = sched_pkg::preg_t'(i);
    end
    for (int i = `ARCH_REG_NUM; i < `PHY_REG_NUM; i++) begin
      m_free.push_back(sched_pkg::preg_t'(i));
    end
    for (int i = 0; i < `PHY_REG_NUM; i++) begin
      m_ready[i] = 1'b1;
    end
    for (int i = 0; i < TAGS; i++) begin
      accepted[i] = 1'b0;
      done[i]     = 1'b0;
    end
    for (int j = 0; j < `WB_WIDTH; j++) begin
      wb_new_v[j] = 1'b0;
      wb_new_p[j] = '0;
      for (int k = 0; k < 3; k++) begin
        wbp_v[j][k] = 1'b0;
        wbp_p[j][k] = '0;
      end
    end

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check(0, "alu issue valid after reset", alu_issue.base.valid, 0);
    check(0, "memory issue valid after reset", mem_issue.base.valid, 0);
    check(0, "req_ready after reset", req_ready, 1);
    report_test(0);

    finished = (n_instr == 0);
    while (!finished) begin
      @(posedge clk);
      // handshakes as the DUT saw them before this edge
      if (req.valid && req_ready) begin
        model_accept(next_idx);
        next_idx++;
      end
      if (req.valid && !req_ready) begin
        stall_cycles++;
      end
      check_hold();
      if (alu_issue.base.valid && alu_ready) begin
        take_issue(0, alu_issue.base, alu_issue.oc);
      end
      if (mem_issue.base.valid && mem_ready) begin
        take_issue(1, mem_issue.base, 4'(mem_issue.oc));
      end
      shift_wb();
      wb_valid <= wb_v_drv;
      wb_pdest <= wb_p_drv;

      // in-order commit returns the previous mapping
      if (commit_ptr < next_idx && done[prog_tag[commit_ptr]]) begin
        commit_tag = prog_tag[commit_ptr];
        commit_ptr++;
        if (exp_dv[commit_tag]) begin
          m_free.push_back(exp_old[commit_tag]);
          free_valid <= 1'b1;
          free_preg  <= exp_old[commit_tag];
        end else begin
          free_valid <= 1'b0;
        end
      end else begin
        free_valid <= 1'b0;
      end

      if (next_idx < n_instr) begin
        req <= make_req(next_idx);
      end else begin
        req <= '0;
      end
      alu_ready <= (($random(seed) & 3) != 0);
      mem_ready <= (($random(seed) & 3) != 0);
      finished = (commit_ptr == n_instr);
    end

    @(posedge clk);
    free_valid <= 1'b0;
    wb_valid   <= '0;
    repeat (2) @(posedge clk);

    check(3, "instructions loaded from the data file", n_instr > 0, 1);
    for (int i = 0; i < n_instr; i++) begin
      check(3, $sformatf("tag %0h issued exactly once", prog_tag[i]),
            issue_cnt[prog_tag[i]], 1);
    end
    check(4, "input stalled at least once", stall_cycles > 0, 1);
    for (int i = 1; i < N_TESTS; i++) begin
      report_test(i);
    end
    for (int i = 0; i < N_TESTS; i++) begin
      total_err += test_err[i];
      if (test_err[i] == 0) begin
        n_passed++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d, stall cycles %0d",
             N_TESTS, n_passed, N_TESTS - n_passed, n_checks, total_err, stall_cycles);
    if (total_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog allows 40 cycles per instruction
  initial begin
    wait (n_instr > 0);
    repeat (n_instr * 40 + 10) @(posedge clk);
    $display("timeout: only %0d of %0d instructions committed after %0d cycles",
             commit_ptr, n_instr, n_instr * 40 + 10);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== scheduler.f ====
+incdir+src
src/sched_pkg.sv
src/free_list.sv
src/rename_stage.sv
src/dispatch_stage.sv
src/reservation_station.sv
src/scheduler_top.sv
testbench/tb_scheduler.sv

// ==== Makefile ====
# Verilator build and run for the scheduler testbench

TOP := tb_scheduler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f scheduler.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" sim.log || \
		(echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== testbench/scheduler_input.txt ====
// columns (hex): class dest src0 src1 oc tag port
// class 0 = ALU, 1 = memory; port 0 = ALU issue, 1 = memory issue
0 05 01 02 3 00 0
1 06 05 00 2 01 1
1 00 06 05 5 02 1
0 00 03 04 1 03 0
0 07 06 06 8 04 0
1 08 00 07 1 05 1
// burst of 40 destination writes, more than the free list holds
0 09 08 07 2 06 0
0 0a 09 09 3 07 0
1 0b 0a 00 1 08 1
0 0c 0b 0a 4 09 0
0 0d 0c 01 5 0a 0
0 0e 0d 0c 6 0b 0
1 0f 0e 00 2 0c 1
0 10 0f 0d 7 0d 0
0 11 10 0e 9 0e 0
0 12 11 10 a 0f 0
1 13 12 00 0 10 1
0 14 13 11 b 11 0
0 15 14 12 c 12 0
0 16 02 03 d 13 0
0 17 15 14 e 14 0
1 18 17 00 1 15 1
0 19 18 16 f 16 0
0 1a 19 17 0 17 0
0 1b 1a 18 1 18 0
1 1c 1b 00 2 19 1
0 1d 1c 1a 2 1a 0
0 1e 1d 1b 3 1b 0
0 1f 1e 1c 4 1c 0
1 01 1f 00 0 1d 1
0 02 01 1f 5 1e 0
0 03 02 01 6 1f 0
0 04 03 02 7 20 0
1 05 04 00 1 21 1
0 06 05 03 8 22 0
0 07 06 05 9 23 0
0 08 07 06 a 24 0
1 09 08 00 2 25 1
0 0a 09 07 b 26 0
0 0b 0a 09 c 27 0
0 0c 0b 0a d 28 0
1 0d 0c 00 1 29 1
0 0e 0d 0b e 2a 0
0 0f 0e 0d f 2b 0
0 05 05 05 1 2c 0
1 05 05 00 0 2d 1
